/* bench/lim_ram_model.svh */
`ifndef LIM_RAM_MODEL_SVH
`define LIM_RAM_MODEL_SVH

// ==============================
// random numbers
// ==============================
logic [lim_mem_pkg::DATA_W-1:0] rnd_state = 32'hd2a6_d40d;

function automatic logic [lim_mem_pkg::DATA_W-1:0] next_rand();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;  // classic LCG constants
    return rnd_state;
endfunction

function automatic int rand_below(input int n);
    return int'(next_rand() % 32'(n));
endfunction

// ==============================
// reference memory
// ==============================
logic [lim_mem_pkg::DATA_W-1:0] ref_mem [WORDS];
lim_op_pkg::lim_op_e            cur_op   = lim_op_pkg::OP_NONE;  // mirror of the funct cell
int                             cur_size = 0;

function automatic bit is_bitwise(input lim_op_pkg::lim_op_e op);
    return (op >= lim_op_pkg::OP_AND) && (op <= lim_op_pkg::OP_XNOR);
endfunction

// old word combined with wdata, plain read for anything else
function automatic logic [lim_mem_pkg::DATA_W-1:0] combine(
    input lim_op_pkg::lim_op_e op,
    input logic [lim_mem_pkg::DATA_W-1:0] old,
    input logic [lim_mem_pkg::DATA_W-1:0] wdata
);
    case (op)
        lim_op_pkg::OP_AND:  return old & wdata;
        lim_op_pkg::OP_OR:   return old | wdata;
        lim_op_pkg::OP_XOR:  return old ^ wdata;
        lim_op_pkg::OP_NAND: return ~(old & wdata);
        lim_op_pkg::OP_NOR:  return ~(old | wdata);
        lim_op_pkg::OP_XNOR: return ~(old ^ wdata);
        default:             return old;
    endcase
endfunction

function automatic logic [lim_mem_pkg::DATA_W-1:0] merge_lanes(
    input logic [lim_mem_pkg::DATA_W-1:0] old,
    input logic [lim_mem_pkg::DATA_W-1:0] nw,
    input logic [lim_mem_pkg::BE_W-1:0]   be
);
    logic [lim_mem_pkg::DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < lim_mem_pkg::BE_W; b++) begin
        if (be[b]) begin
            res[b*lim_mem_pkg::LANE_W +: lim_mem_pkg::LANE_W] =
                nw[b*lim_mem_pkg::LANE_W +: lim_mem_pkg::LANE_W];
        end
    end
    return res;
endfunction

function automatic void update_model(
    input int                             word,
    input logic [lim_mem_pkg::BE_W-1:0]   be,
    input logic [lim_mem_pkg::DATA_W-1:0] wdata
);
    if (is_bitwise(cur_op) && cur_size >= 2) begin
        for (int i = word; i < word + cur_size && i < WORDS; i++) begin
            ref_mem[i] = combine(cur_op, ref_mem[i], wdata);  // whole words, clipped at the end
        end
    end else if (is_bitwise(cur_op)) begin
        ref_mem[word] = merge_lanes(ref_mem[word], combine(cur_op, ref_mem[word], wdata), be);
    end else begin
        ref_mem[word] = merge_lanes(ref_mem[word], wdata, be);  // NONE, MAX and MIN write plainly
    end
endfunction

// unsigned max or min over the range
function automatic logic [lim_mem_pkg::DATA_W-1:0] search_ref(
    input lim_op_pkg::lim_op_e op,
    input int                  start,
    input int                  size
);
    logic [lim_mem_pkg::DATA_W-1:0] best;
    int                             last;
    bit                             better;
    best = ref_mem[start];
    last = (size < 2) ? start : start + size - 1;
    if (last > WORDS - 1) begin
        last = WORDS - 1;
    end
    for (int i = start + 1; i <= last; i++) begin
        better = (op == lim_op_pkg::OP_MAX) ? (ref_mem[i] > best) : (ref_mem[i] < best);
        if (better) begin
            best = ref_mem[i];
        end
    end
    return best;
endfunction

`endif

/* bench/lim_ram_tb.sv */
module lim_ram_tb;

    localparam int ADDR_WIDTH = 8;
    localparam int WORDS      = 2**(ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W);
    localparam int DATA_WORDS = WORDS - 1;  // top word is the funct cell
    localparam int TIMEOUT    = 100;

    logic                           clk_i = 1'b0;
    logic                           rst_ni;
    logic                           en_a_i;
    logic [ADDR_WIDTH-1:0]          addr_a_i;
    logic [lim_mem_pkg::DATA_W-1:0] rdata_a_o;
    logic                           req_b_i;
    logic [ADDR_WIDTH-1:0]          addr_b_i;
    logic                           we_b_i;
    logic [lim_mem_pkg::BE_W-1:0]   be_b_i;
    logic [lim_mem_pkg::DATA_W-1:0] wdata_b_i;
    logic                           gnt_b_o;
    logic                           rvalid_b_o;
    logic [lim_mem_pkg::DATA_W-1:0] rdata_b_o;

    logic [lim_mem_pkg::DATA_W-1:0] exp_data;     // expected port B read data
    logic [lim_mem_pkg::DATA_W-1:0] exp_a;        // expected port A data
    bit                             exp_check;    // response carries data to check
    bit                             a_check;
    bit                             idle_check;
    bit                             search_wait;  // grant must stay low while a search runs
    bit                             stalled;      // port B stopped answering
    int                             checks;
    int                             errors;
    int                             timeouts;
    int                             sent;
    int                             seen;

    `include "lim_ram_model.svh"

    always #4 clk_i = ~clk_i;

    lim_ram_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lim_ram_top (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .en_a_i     (en_a_i),
        .addr_a_i   (addr_a_i),
        .rdata_a_o  (rdata_a_o),
        .req_b_i    (req_b_i),
        .addr_b_i   (addr_b_i),
        .we_b_i     (we_b_i),
        .be_b_i     (be_b_i),
        .wdata_b_i  (wdata_b_i),
        .gnt_b_o    (gnt_b_o),
        .rvalid_b_o (rvalid_b_o),
        .rdata_b_o  (rdata_b_o)
    );

    // ==============================
    // response checker
    // ==============================
    always @(negedge clk_i) begin
        if (idle_check) begin
            checks++;
            assert (rvalid_b_o === 1'b0 && gnt_b_o === 1'b1) else begin
                errors++;
                $display("ERR rvalid_b_o/gnt_b_o got %h/%h expected 0/1", rvalid_b_o, gnt_b_o);
            end
        end
        if (a_check) begin
            checks++;
            assert (rdata_a_o === exp_a) else begin
                errors++;
                $display("ERR rdata_a_o got %h expected %h", rdata_a_o, exp_a);
            end
        end
        if (rvalid_b_o) begin
            seen++;
            if (exp_check) begin
                checks++;
                assert (rdata_b_o === exp_data) else begin
                    errors++;
                    $display("ERR rdata_b_o got %h expected %h", rdata_b_o, exp_data);
                end
            end
        end else if (search_wait) begin
            checks++;
            assert (gnt_b_o === 1'b0) else begin
                errors++;
                $display("ERR gnt_b_o got %h expected 0", gnt_b_o);
            end
        end
    end

    // ==============================
    // port B access tasks
    // ==============================
    task automatic finish_run();
        $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("%s", what);
        timeouts++;
        stalled = 1'b1;
    endtask

    // starts and ends on a rising edge
    task automatic issue(input logic we, input int word, input logic [lim_mem_pkg::BE_W-1:0] be,
                         input logic [lim_mem_pkg::DATA_W-1:0] wdata, input bit search);
        int tmo;
        tmo = 0;
        if (!stalled) begin
            req_b_i   <= 1'b1;
            we_b_i    <= we;
            addr_b_i  <= ADDR_WIDTH'(word) << lim_mem_pkg::BYTE_OFS_W;
            be_b_i    <= be;
            wdata_b_i <= wdata;
            sent++;
            @(negedge clk_i);
            while (!gnt_b_o && tmo < TIMEOUT) begin
                tmo++;
                @(negedge clk_i);
            end
            if (!gnt_b_o) begin
                report_timeout("timeout waiting for a grant on port B");
            end else begin
                @(posedge clk_i);  // accepted on this edge
                req_b_i     <= 1'b0;
                search_wait = search;
                tmo         = 0;
                while (seen < sent && tmo < TIMEOUT) begin
                    tmo++;
                    @(posedge clk_i);
                end
                search_wait = 1'b0;
                if (seen < sent) begin
                    report_timeout("timeout waiting for a response on port B");
                end
            end
        end
    endtask

    task automatic write_word(input int word, input logic [lim_mem_pkg::BE_W-1:0] be,
                              input logic [lim_mem_pkg::DATA_W-1:0] wdata);
        exp_check = 1'b0;
        issue(1'b1, word, be, wdata, 1'b0);
        update_model(word, be, wdata);
    endtask

    task automatic read_word(input int word, input logic [lim_mem_pkg::DATA_W-1:0] wdata);
        bit search;
        search = (cur_op == lim_op_pkg::OP_MAX) || (cur_op == lim_op_pkg::OP_MIN);
        if (search) begin
            exp_data = search_ref(cur_op, word, cur_size);
        end else begin
            exp_data = combine(cur_op, ref_mem[word], wdata);
        end
        exp_check = 1'b1;
        issue(1'b0, word, '1, wdata, search);
    endtask

    task automatic program_funct(input lim_op_pkg::lim_op_e op, input int size);
        exp_check = 1'b0;
        issue(1'b1, WORDS - 1, '1, {lim_op_pkg::SIZE_W'(size), op}, 1'b0);
        cur_op   = op;
        cur_size = size;
    endtask

    task automatic read_port_a(input int word);
        en_a_i   <= 1'b1;
        addr_a_i <= ADDR_WIDTH'(word) << lim_mem_pkg::BYTE_OFS_W;
        exp_a    = ref_mem[word];
        @(posedge clk_i);
        en_a_i   <= 1'b0;
        a_check  = 1'b1;  // data registered on this edge
        @(posedge clk_i);
        a_check  = 1'b0;
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        int                  word;
        int                  size;
        lim_op_pkg::lim_op_e op;
        rst_ni    = 1'b0;
        en_a_i    = 1'b0;
        addr_a_i  = '0;
        req_b_i   = 1'b0;
        addr_b_i  = '0;
        we_b_i    = 1'b0;
        be_b_i    = '0;
        wdata_b_i = '0;
        repeat (3) @(posedge clk_i);
        rst_ni     <= 1'b1;
        idle_check = 1'b1;
        @(posedge clk_i);
        idle_check = 1'b0;

        for (int w = 0; w < DATA_WORDS; w++) begin
            write_word(w, '1, next_rand());  // give every data word a known value
        end
        repeat (24) begin
            write_word(rand_below(DATA_WORDS), 4'(rand_below(16)), next_rand());
        end
        repeat (16) begin
            word = rand_below(DATA_WORDS);
            read_word(word, next_rand());
            read_port_a(word);
        end

        // single-word ops and then ranged writes
        for (int k = 1; k <= 6; k++) begin
            op = lim_op_pkg::lim_op_e'(8'(k));
            program_funct(op, 1);
            read_word(rand_below(DATA_WORDS), next_rand());
            write_word(rand_below(DATA_WORDS), 4'(rand_below(16)), next_rand());
            size = 2 + rand_below(7);
            program_funct(op, size);
            write_word(rand_below(DATA_WORDS - size + 1), '1, next_rand());
        end

        for (int k = 0; k < 6; k++) begin
            op   = (k % 2 == 0) ? lim_op_pkg::OP_MAX : lim_op_pkg::OP_MIN;
            size = 2 + rand_below(15);
            program_funct(op, size);
            read_word(rand_below(DATA_WORDS - size + 1), '0);
        end

        // plain sweep catches any stray write
        program_funct(lim_op_pkg::OP_NONE, 0);
        for (int w = 0; w < DATA_WORDS; w++) begin
            read_word(w, next_rand());
        end
        finish_run();
    end

endmodule

/* flist.f */
+incdir+bench
hdl/lim_op_pkg.sv
hdl/lim_mem_pkg.sv
hdl/lim_range_decoder.sv
hdl/lim_array.sv
hdl/lim_maxmin.sv
hdl/lim_port_ctrl.sv
hdl/lim_ram_top.sv
bench/lim_ram_tb.sv

/* hdl/lim_array.sv */
module lim_array #(
    parameter int ADDR_WIDTH = 8,
    localparam int WORD_AW = ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W,
    localparam int DEPTH = 2**WORD_AW
) (
    input  logic                                       clk_i,
    input  logic                                       en_a_i,
    input  logic [ADDR_WIDTH-1:0]                      addr_a_i,
    input  logic                                       wr_i,
    input  logic                                       rd_i,
    input  lim_op_pkg::lim_op_e                        op_i,
    input  logic [lim_mem_pkg::DATA_W-1:0]             mask_i,
    input  logic [DEPTH-1:0]                           word_en_i,
    input  logic [lim_mem_pkg::BE_W-1:0]               lane_en_i,
    output logic [lim_mem_pkg::DATA_W-1:0]             rdata_a_o,
    output logic [lim_mem_pkg::DATA_W-1:0]             rd_data_o,
    output logic [DEPTH-1:0][lim_mem_pkg::DATA_W-1:0]  words_o
);

    logic [DEPTH-1:0][lim_mem_pkg::DATA_W-1:0] mem_q;
    logic [DEPTH-1:0][lim_mem_pkg::DATA_W-1:0] op_res;  // word combined with mask
    logic                                      is_bitwise;

    // ==============================
    // in-array logic
    // ==============================
    always_comb begin
        logic [lim_mem_pkg::DATA_W-1:0] and_w;
        logic [lim_mem_pkg::DATA_W-1:0] or_w;
        logic [lim_mem_pkg::DATA_W-1:0] xor_w;
        is_bitwise = 1'b1;
        for (int i = 0; i < DEPTH; i++) begin
            and_w = mem_q[i] & mask_i;
            or_w  = mem_q[i] | mask_i;
            xor_w = mem_q[i] ^ mask_i;
            case (op_i)
                lim_op_pkg::OP_AND:  op_res[i] = and_w;
                lim_op_pkg::OP_OR:   op_res[i] = or_w;
                lim_op_pkg::OP_XOR:  op_res[i] = xor_w;
                lim_op_pkg::OP_NAND: op_res[i] = ~and_w;
                lim_op_pkg::OP_NOR:  op_res[i] = ~or_w;
                lim_op_pkg::OP_XNOR: op_res[i] = ~xor_w;
                default: begin
                    op_res[i]  = mem_q[i];  // plain read
                    is_bitwise = 1'b0;
                end
            endcase
        end
    end

    // ==============================
    // port B write-back and read
    // ==============================
    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                for (int b = 0; b < lim_mem_pkg::BE_W; b++) begin
                    if (word_en_i[i] && lane_en_i[b]) begin
                        mem_q[i][b*lim_mem_pkg::LANE_W +: lim_mem_pkg::LANE_W] <= is_bitwise ?
                            op_res[i][b*lim_mem_pkg::LANE_W +: lim_mem_pkg::LANE_W] :
                            mask_i[b*lim_mem_pkg::LANE_W +: lim_mem_pkg::LANE_W];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (word_en_i[i]) begin
                    rd_data_o <= op_res[i];
                end
            end
        end
    end

    // instruction port, word aligned
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            rdata_a_o <= mem_q[addr_a_i[ADDR_WIDTH-1:lim_mem_pkg::BYTE_OFS_W]];
        end
    end

    assign words_o = mem_q;

endmodule

/* hdl/lim_maxmin.sv */
module lim_maxmin #(
    parameter int ADDR_WIDTH = 8,
    localparam int WORD_AW = ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W,
    localparam int DEPTH = 2**WORD_AW
) (
    input  logic                                       clk_i,
    input  lim_op_pkg::lim_op_e                        op_i,
    input  logic [lim_mem_pkg::DATA_W-1:0]             mask_i,
    input  logic [DEPTH-1:0]                           word_en_i,
    input  logic [DEPTH-1:0][lim_mem_pkg::DATA_W-1:0]  words_i,
    input  logic                                       search_start_i,
    input  logic                                       search_step_i,
    output logic [lim_mem_pkg::DATA_W-1:0]             result_data_o
);

    logic [DEPTH-1:0] enabled_q;  // rows still in the race
    logic [DEPTH-1:0] wired_or;   // masked OR per row
    logic [DEPTH-1:0] cand;
    logic [DEPTH-1:0] enabled_d;

    // ==============================
    // one search step
    // ==============================
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            wired_or[i] = |(words_i[i] & mask_i);
        end
        case (op_i)
            lim_op_pkg::OP_MAX: cand = enabled_q & wired_or;   // keep rows with the bit set
            lim_op_pkg::OP_MIN: cand = enabled_q & ~wired_or;  // keep rows with the bit clear
            default:            cand = '0;
        endcase
        // empty candidate set means every row agreed on this bit
        enabled_d = (|cand) ? cand : enabled_q;
    end

    always_ff @(posedge clk_i) begin
        if (search_start_i) begin
            enabled_q <= word_en_i;
        end else if (search_step_i) begin
            enabled_q <= enabled_d;
        end
    end

    // highest surviving row wins ties
    always_comb begin
        result_data_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (enabled_q[i]) begin
                result_data_o = words_i[i];
            end
        end
    end

endmodule

/* hdl/lim_mem_pkg.sv */
package lim_mem_pkg;

    // ==============================
    // word geometry
    // ==============================
    localparam int DATA_W     = 32;  // word width
    localparam int BE_W       = 4;   // byte lanes per word
    localparam int BYTE_OFS_W = 2;   // byte offset bits in an address

    // one byte per lane
    localparam int LANE_W = DATA_W / BE_W;

endpackage

/* hdl/lim_op_pkg.sv */
package lim_op_pkg;

    // ==============================
    // funct cell layout
    // ==============================
    localparam int OP_W   = 8;   // opcode field, bits 7:0
    localparam int SIZE_W = 24;  // range size in words, bits 31:8

    // ==============================
    // opcodes
    // ==============================
    typedef enum logic [OP_W-1:0] {
        OP_NONE = 8'h00,  // plain memory
        OP_AND  = 8'h01,
        OP_OR   = 8'h02,
        OP_XOR  = 8'h03,
        OP_NAND = 8'h04,
        OP_NOR  = 8'h05,
        OP_XNOR = 8'h06,
        OP_MAX  = 8'h07,  // bit-serial unsigned max search
        OP_MIN  = 8'h08   // bit-serial unsigned min search
    } lim_op_e;

endpackage

/* hdl/lim_port_ctrl.sv */
module lim_port_ctrl #(
    parameter int ADDR_WIDTH = 8,
    localparam int WORD_AW = ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W,
    localparam int FUNCT_WORD = 2**WORD_AW - 1
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              req_b_i,
    input  logic [ADDR_WIDTH-1:0]             addr_b_i,
    input  logic                              we_b_i,
    input  logic [lim_mem_pkg::BE_W-1:0]      be_b_i,
    input  logic [lim_mem_pkg::DATA_W-1:0]    wdata_b_i,
    input  logic [lim_mem_pkg::DATA_W-1:0]    rd_data_i,
    input  logic [lim_mem_pkg::DATA_W-1:0]    result_data_i,
    output logic                              gnt_b_o,
    output logic                              rvalid_b_o,
    output logic [lim_mem_pkg::DATA_W-1:0]    rdata_b_o,
    output logic [WORD_AW-1:0]                start_word_o,
    output logic [lim_op_pkg::SIZE_W-1:0]     size_o,
    output logic [lim_mem_pkg::BE_W-1:0]      be_o,
    output logic                              wr_o,
    output logic                              rd_o,
    output lim_op_pkg::lim_op_e               op_o,
    output logic [lim_mem_pkg::DATA_W-1:0]    mask_o,
    output logic                              search_start_o,
    output logic                              search_step_o
);

    logic [lim_mem_pkg::DATA_W-1:0] funct_q;      // opcode and range size
    lim_op_pkg::lim_op_e            opcode;
    logic [lim_op_pkg::SIZE_W-1:0]  funct_size;
    logic [WORD_AW-1:0]             req_word;
    logic                           is_funct;     // access hits the funct cell
    logic                           bitwise_op;
    logic                           search_op;
    logic                           range_ok;
    logic                           accept;
    logic                           search_go;
    logic                           busy_q;       // search in progress
    logic [lim_mem_pkg::DATA_W-1:0] bit_q;        // one-hot search bit
    logic                           rvalid_q;
    logic                           resp_search_q;

    // ==============================
    // request decode
    // ==============================
    assign opcode     = lim_op_pkg::lim_op_e'(funct_q[lim_op_pkg::OP_W-1:0]);
    assign funct_size = funct_q[lim_op_pkg::OP_W +: lim_op_pkg::SIZE_W];
    assign req_word   = addr_b_i[ADDR_WIDTH-1:lim_mem_pkg::BYTE_OFS_W];
    assign is_funct   = (req_word == WORD_AW'(FUNCT_WORD));
    assign accept     = req_b_i & gnt_b_o;
    assign search_go  = accept & ~we_b_i & ~is_funct & search_op;

    always_comb begin
        bitwise_op = 1'b0;
        search_op  = 1'b0;
        case (opcode)
            lim_op_pkg::OP_AND, lim_op_pkg::OP_OR, lim_op_pkg::OP_XOR,
            lim_op_pkg::OP_NAND, lim_op_pkg::OP_NOR, lim_op_pkg::OP_XNOR: begin
                bitwise_op = 1'b1;
            end
            lim_op_pkg::OP_MAX, lim_op_pkg::OP_MIN: begin
                search_op = 1'b1;
            end
            default: begin
                bitwise_op = 1'b0;
            end
        endcase
    end

    // only ranged writes and searches look at the programmed size
    assign range_ok = (search_op & ~we_b_i) | (bitwise_op & we_b_i);

    always_comb begin
        op_o = opcode;
        if (!busy_q && (is_funct || (we_b_i && search_op))) begin
            op_o = lim_op_pkg::OP_NONE;  // funct access and search-mode writes are plain
        end
    end

    assign start_word_o   = req_word;
    assign size_o         = range_ok ? funct_size : {{(lim_op_pkg::SIZE_W-1){1'b0}}, 1'b1};
    assign be_o           = be_b_i;
    assign wr_o           = accept & we_b_i & ~is_funct;
    assign rd_o           = accept & ~we_b_i & ~is_funct & ~search_op;
    assign mask_o         = busy_q ? bit_q : wdata_b_i;
    assign search_start_o = search_go;
    assign search_step_o  = busy_q;

    // ==============================
    // funct cell and search sequencing
    // ==============================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            funct_q       <= '0;
            busy_q        <= 1'b0;
            bit_q         <= '0;
            rvalid_q      <= 1'b0;
            resp_search_q <= 1'b0;
        end else begin
            if (accept && we_b_i && is_funct) begin
                funct_q <= wdata_b_i;
            end
            if (search_go) begin
                busy_q <= 1'b1;
                bit_q  <= {1'b1, {(lim_mem_pkg::DATA_W-1){1'b0}}};  // start at the MSB
            end else if (busy_q) begin
                bit_q <= bit_q >> 1;
                if (bit_q[0]) begin
                    busy_q <= 1'b0;  // last bit evaluated
                end
            end
            rvalid_q      <= (accept & ~search_go) | (busy_q & bit_q[0]);
            resp_search_q <= busy_q & bit_q[0];
        end
    end

    assign gnt_b_o    = ~busy_q;
    assign rvalid_b_o = rvalid_q;
    assign rdata_b_o  = resp_search_q ? result_data_i : rd_data_i;

endmodule

/* hdl/lim_ram_top.sv */
module lim_ram_top #(
    parameter int ADDR_WIDTH = 8,
    localparam int WORD_AW = ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W,
    localparam int DEPTH = 2**WORD_AW
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           en_a_i,
    input  logic [ADDR_WIDTH-1:0]          addr_a_i,
    output logic [lim_mem_pkg::DATA_W-1:0] rdata_a_o,
    input  logic                           req_b_i,
    input  logic [ADDR_WIDTH-1:0]          addr_b_i,
    input  logic                           we_b_i,
    input  logic [lim_mem_pkg::BE_W-1:0]   be_b_i,
    input  logic [lim_mem_pkg::DATA_W-1:0] wdata_b_i,
    output logic                           gnt_b_o,
    output logic                           rvalid_b_o,
    output logic [lim_mem_pkg::DATA_W-1:0] rdata_b_o
);

    logic [WORD_AW-1:0]                        start_word;
    logic [lim_op_pkg::SIZE_W-1:0]             size;
    logic [lim_mem_pkg::BE_W-1:0]              be;
    logic                                      wr;
    logic                                      rd;
    lim_op_pkg::lim_op_e                       op;
    logic [lim_mem_pkg::DATA_W-1:0]            mask;
    logic                                      search_start;
    logic                                      search_step;
    logic [DEPTH-1:0]                          word_en;
    logic [lim_mem_pkg::BE_W-1:0]              lane_en;
    logic [DEPTH-1:0][lim_mem_pkg::DATA_W-1:0] words;
    logic [lim_mem_pkg::DATA_W-1:0]            rd_data;
    logic [lim_mem_pkg::DATA_W-1:0]            result_data;

    // ==============================
    // port B control
    // ==============================
    lim_port_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lim_port_ctrl (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_b_i        (req_b_i),
        .addr_b_i       (addr_b_i),
        .we_b_i         (we_b_i),
        .be_b_i         (be_b_i),
        .wdata_b_i      (wdata_b_i),
        .rd_data_i      (rd_data),
        .result_data_i  (result_data),
        .gnt_b_o        (gnt_b_o),
        .rvalid_b_o     (rvalid_b_o),
        .rdata_b_o      (rdata_b_o),
        .start_word_o   (start_word),
        .size_o         (size),
        .be_o           (be),
        .wr_o           (wr),
        .rd_o           (rd),
        .op_o           (op),
        .mask_o         (mask),
        .search_start_o (search_start),
        .search_step_o  (search_step)
    );

    lim_range_decoder #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lim_range_decoder (
        .start_word_i (start_word),
        .size_i       (size),
        .be_i         (be),
        .word_en_o    (word_en),
        .lane_en_o    (lane_en)
    );

    // ==============================
    // storage and search
    // ==============================
    lim_array #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lim_array (
        .clk_i     (clk_i),
        .en_a_i    (en_a_i),
        .addr_a_i  (addr_a_i),
        .wr_i      (wr),
        .rd_i      (rd),
        .op_i      (op),
        .mask_i    (mask),
        .word_en_i (word_en),
        .lane_en_i (lane_en),
        .rdata_a_o (rdata_a_o),
        .rd_data_o (rd_data),
        .words_o   (words)
    );

    lim_maxmin #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_lim_maxmin (
        .clk_i          (clk_i),
        .op_i           (op),
        .mask_i         (mask),
        .word_en_i      (word_en),
        .words_i        (words),
        .search_start_i (search_start),
        .search_step_i  (search_step),
        .result_data_o  (result_data)
    );

endmodule

/* hdl/lim_range_decoder.sv */
module lim_range_decoder #(
    parameter int ADDR_WIDTH = 8,
    localparam int WORD_AW = ADDR_WIDTH - lim_mem_pkg::BYTE_OFS_W,
    localparam int DEPTH = 2**WORD_AW
) (
    input  logic [WORD_AW-1:0]            start_word_i,
    input  logic [lim_op_pkg::SIZE_W-1:0] size_i,
    input  logic [lim_mem_pkg::BE_W-1:0]  be_i,
    output logic [DEPTH-1:0]              word_en_o,
    output logic [lim_mem_pkg::BE_W-1:0]  lane_en_o
);

    logic ranged;

    assign ranged = (size_i >= lim_op_pkg::SIZE_W'(2));

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            if (ranged) begin
                // words past the last row simply do not exist
                word_en_o[i] = (i >= int'(start_word_i)) &&
                               ((i - int'(start_word_i)) < int'(size_i));
            end else begin
                word_en_o[i] = (i == int'(start_word_i));
            end
        end
    end

    assign lane_en_o = ranged ? {lim_mem_pkg::BE_W{1'b1}} : be_i;  // ranges are word wide

endmodule

/* run.sh */
#!/bin/sh
# build and run the lim_ram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module lim_ram_tb -o lim_ram_sim

out=$(./obj_dir/lim_ram_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1
